/* common/display_consts.svh */
// Widths, digit count and refresh rate for the numeric display

`ifndef DISPLAY_CONSTS_SVH
`define DISPLAY_CONSTS_SVH

// Binary input value
`define INPUT_BITS 16

// Decimal digits produced and shown
`define OUTPUT_DIGITS 5
`define OUTPUT_BITS (4 * `OUTPUT_DIGITS)

// Converter bit counter, holds INPUT_BITS-1 down to 0
`define COUNT_BITS ($clog2(`INPUT_BITS))

// Clock cycles each digit stays lit, kept tiny for simulation
`define REFRESH_CYCLES 4

// Digit index of the scanner
`define SCAN_BITS 3

`endif

/* common/DisplayPkg.sv */
// Types shared by the display design: converter and scanner states, BCD, binary and segment words

`include "display_consts.svh"

package DisplayPkg;

	// Converter phase, shift or add-three
	typedef enum logic {
		Double,
		Dabble
	} ConvState;

	// One decimal digit
	typedef logic [3:0] BcdDigit;

	// Packed digits, element 0 is the ones digit
	typedef BcdDigit [`OUTPUT_DIGITS-1:0] BcdWord;

	// Unsigned input value
	typedef logic [`INPUT_BITS-1:0] BinaryWord;

	// Segment lines, bit 0 is a and bit 6 is g
	// A low bit lights the segment
	typedef logic [6:0] SegmentWord;

	// Digit currently driven by the scanner
	typedef enum logic [`SCAN_BITS-1:0] {
		Digit0,
		Digit1,
		Digit2,
		Digit3,
		Digit4
	} ScanState;

endpackage

/* common/ConvertIf.sv */
// Interface between conversion control and the BCD converter, with requester and converter modports

`timescale 1ns/1ns

interface ConvertIf;
	import DisplayPkg::*;

	// One-cycle request, only while Busy is low
	logic Start;

	// Value to convert, sampled with Start
	BinaryWord Binary;

	// Conversion running
	logic Busy;

	// Result ready, one cycle
	logic Done;

	modport Requester (
		output Start,
		output Binary,
		input  Busy,
		input  Done
	);

	modport Converter (
		input  Start,
		input  Binary,
		output Busy,
		output Done
	);

endinterface

/* rtl/ConversionControl.sv */
// Load strobe handling with a single pending slot and start pulse generation for the converter

`timescale 1ns/1ns

module ConversionControl (
	input  logic                  Clock,
	input  logic                  Reset,
	input  logic                  Load_i,
	input  DisplayPkg::BinaryWord Value_i,
	ConvertIf.Requester           Conv
);
	import DisplayPkg::*;

	// Last loaded value, feeds the converter directly
	BinaryWord Held;

	// Start raised by a load into an idle converter
	// Also marks a start that Busy has not answered yet
	logic StartIssued;

	// A value waits for the current conversion to end
	logic Pending;

	// Pending value leaves in the Done cycle
	logic Resume;

	// Load that can start at once
	logic Accept;

	assign Resume = Conv.Done && Pending;
	assign Accept = Load_i && !Conv.Busy && !Conv.Start && !Pending;

	assign Conv.Start  = StartIssued || Resume;
	assign Conv.Binary = Held;

	// Converter samples Held on the same edge a new load overwrites it,
	// so the latest load can always go straight in here
	always_ff @(posedge Clock) begin
		if (Load_i) begin
			Held <= Value_i;
		end
	end

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			StartIssued <= 1'b0;
			Pending     <= 1'b0;
		end else begin
			StartIssued <= Accept;

			// Latest load wins the slot, even over a resume
			if (Load_i && !Accept) begin
				Pending <= 1'b1;
			end else if (Resume) begin
				Pending <= 1'b0;
			end
		end
	end

	// The converter would restart and lose the running value
	StartOnlyWhenIdle: assert property (
		@(posedge Clock) disable iff (!Reset)
		!(Conv.Start && Conv.Busy)
	) else $error("Start issued while converter busy");

	// Every held value must eventually reach the converter
	PendingDrains: assert property (
		@(posedge Clock) disable iff (!Reset)
		Pending && !Conv.Busy && !Conv.Start |-> 1'b0
	) else $error("Pending value with no conversion to release it");

endmodule

/* DoubleDabble/DoubleDabble.sv */
// Sequential shift-and-add-three converter from binary to packed BCD digits

`timescale 1ns/1ns

`include "display_consts.svh"

module DoubleDabble (
	input  logic               Clock,
	input  logic               Reset,
	ConvertIf.Converter        Conv,
	output DisplayPkg::BcdWord Bcd_o
);
	import DisplayPkg::*;

	localparam logic [`COUNT_BITS-1:0] FirstCount = `COUNT_BITS'(`INPUT_BITS - 1);

	ConvState State;
	logic [`COUNT_BITS-1:0] Counter;

	// Working registers, binary shifts out into the BCD side
	BinaryWord Binary;
	logic [`OUTPUT_BITS-1:0] Shift;

	// Control and result
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			State     <= Double;
			Counter   <= '0;
			Conv.Busy <= 1'b0;
			Conv.Done <= 1'b0;
			Bcd_o     <= '0;
		end else begin
			// Done never lasts past one cycle
			Conv.Done <= 1'b0;

			if (Conv.Start) begin
				Conv.Busy <= 1'b1;
				State     <= Double;
				Counter   <= FirstCount;
			end else if (Conv.Busy) begin
				if (State == Double) begin
					State <= Dabble;
				end else begin
					State <= Double;
					if (Counter != '0) begin
						Counter <= Counter - 1'b1;
					end else begin
						// Last shift is done, the final add-three is not needed
						Conv.Busy <= 1'b0;
						Conv.Done <= 1'b1;
						Bcd_o     <= Shift;
					end
				end
			end
		end
	end

	// Datapath
	always_ff @(posedge Clock) begin
		if (Conv.Start) begin
			Binary <= Conv.Binary;
			Shift  <= '0;
		end else if (Conv.Busy) begin
			if (State == Double) begin
				Shift  <= {Shift[`OUTPUT_BITS-2:0], Binary[`INPUT_BITS-1]};
				Binary <= {Binary[`INPUT_BITS-2:0], 1'b0};
			end else begin
				// Digits of five or more would overflow on the next shift
				for (int k = 0; k < `OUTPUT_DIGITS; k++) begin
					if (Shift[4*k +: 4] >= 4'd5) begin
						Shift[4*k +: 4] <= Shift[4*k +: 4] + 4'd3;
					end
				end
			end
		end
	end

	DonePulse: assert property (
		@(posedge Clock) disable iff (!Reset)
		Conv.Done |=> !Conv.Done
	) else $error("Done longer than one cycle");

	DoneNotBusy: assert property (
		@(posedge Clock) disable iff (!Reset)
		!(Conv.Done && Conv.Busy)
	) else $error("Done and Busy high together");

endmodule

/* DisplayScanner/DisplayScanner.sv */
// Digit latch, leading-zero blanking, segment decode and digit enable rotation for the display

`timescale 1ns/1ns

`include "display_consts.svh"

module DisplayScanner (
	input  logic                     Clock,
	input  logic                     Reset,
	input  logic                     Done_i,
	input  DisplayPkg::BcdWord       Bcd_i,
	output DisplayPkg::SegmentWord   Segments_o,
	output logic [`OUTPUT_DIGITS-1:0] DigitEnable_o
);
	import DisplayPkg::*;

	localparam int RefreshBits = $clog2(`REFRESH_CYCLES + 1);
	localparam logic [RefreshBits-1:0] LastRefresh = RefreshBits'(`REFRESH_CYCLES - 1);
	localparam ScanState LastDigit = ScanState'(`OUTPUT_DIGITS - 1);

	// Digits on the display
	BcdWord Shown;

	logic [RefreshBits-1:0] RefreshCount;
	ScanState Index;

	// Highest nonzero digit, 0 when the value is zero
	logic [`SCAN_BITS-1:0] TopDigit;

	BcdDigit Current;
	logic Blank;

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			Shown        <= '0;
			RefreshCount <= '0;
			Index        <= Digit0;
		end else begin
			if (Done_i) begin
				Shown <= Bcd_i;
			end

			if (RefreshCount == LastRefresh) begin
				RefreshCount <= '0;
				if (Index == LastDigit) begin
					Index <= Digit0;
				end else begin
					Index <= ScanState'(Index + 1'b1);
				end
			end else begin
				RefreshCount <= RefreshCount + 1'b1;
			end
		end
	end

	// Digit 0 is never blanked, so the search starts at 1
	always_comb begin
		TopDigit = '0;
		for (int k = 1; k < `OUTPUT_DIGITS; k++) begin
			if (Shown[k] != 4'd0) begin
				TopDigit = `SCAN_BITS'(k);
			end
		end
	end

	assign Current = Shown[Index];
	assign Blank   = Index > TopDigit;

	// Segment table gfedcba, active low
	always_comb begin
		if (Blank) begin
			Segments_o = 7'h7F;
		end else begin
			case (Current)
				4'd0:    Segments_o = 7'h40;
				4'd1:    Segments_o = 7'h79;
				4'd2:    Segments_o = 7'h24;
				4'd3:    Segments_o = 7'h30;
				4'd4:    Segments_o = 7'h19;
				4'd5:    Segments_o = 7'h12;
				4'd6:    Segments_o = 7'h02;
				4'd7:    Segments_o = 7'h78;
				4'd8:    Segments_o = 7'h00;
				4'd9:    Segments_o = 7'h10;
				// Not a decimal digit, keep it dark
				default: Segments_o = 7'h7F;
			endcase
		end
	end

	assign DigitEnable_o = ~(`OUTPUT_DIGITS'(1) << Index);

	// Index must stay inside the digit range for the enable to be valid
	OneDigitLit: assert property (
		@(posedge Clock) disable iff (!Reset)
		$onehot(~DigitEnable_o)
	) else $error("Digit enable not one-hot low");

endmodule

/* rtl/ValueDisplay.sv */
// Top level of the numeric display: conversion control, BCD converter and display scanner

`timescale 1ns/1ns

`include "display_consts.svh"

module ValueDisplay (
	input  logic                      Clock,
	input  logic                      Reset,
	input  logic                      Load_i,
	input  DisplayPkg::BinaryWord     Value_i,
	output DisplayPkg::BcdWord        Bcd_o,
	output logic                      BcdValid_o,
	output DisplayPkg::SegmentWord    Segments_o,
	output logic [`OUTPUT_DIGITS-1:0] DigitEnable_o
);

	// Control to converter
	ConvertIf Conv ();

	ConversionControl i_ConversionControl (
		.Clock   (Clock),
		.Reset   (Reset),
		.Load_i  (Load_i),
		.Value_i (Value_i),
		.Conv    (Conv.Requester)
	);

	DoubleDabble i_DoubleDabble (
		.Clock (Clock),
		.Reset (Reset),
		.Conv  (Conv.Converter),
		.Bcd_o (Bcd_o)
	);

	// Result strobe is the converter's Done pulse
	assign BcdValid_o = Conv.Done;

	DisplayScanner i_DisplayScanner (
		.Clock         (Clock),
		.Reset         (Reset),
		.Done_i        (Conv.Done),
		.Bcd_i         (Bcd_o),
		.Segments_o    (Segments_o),
		.DigitEnable_o (DigitEnable_o)
	);

endmodule

/* verif/ClockGen.sv */
// Testbench clock and active-low reset generator

`timescale 1ns/1ns

module ClockGen (
	output logic Clock,
	output logic Reset
);

	// 100 ns period
	localparam int HalfPeriod = 50;
	localparam int ResetCycles = 5;

	initial begin
		Clock = 1'b0;
		forever #HalfPeriod Clock = ~Clock;
	end

	// Release on a falling edge, away from the sampling edge
	initial begin
		Reset = 1'b0;
		repeat (ResetCycles) @(posedge Clock);
		@(negedge Clock);
		Reset = 1'b1;
	end

endmodule

/* verif/ValueDisplayTb.sv */
// Testbench for the numeric display: stimulus, reference model, compare tasks, scoreboard, watchdog

`timescale 1ns/1ns

`include "display_consts.svh"

module ValueDisplayTb;
	import DisplayPkg::*;

	// Load edge to Done edge
	localparam int Latency = 2 * `INPUT_BITS + 1;
	localparam int RandomLoads = 200;
	localparam int ScanValues = 4;
	localparam int TestCount = 6 + RandomLoads + 2 + 2 * ScanValues + 2;
	localparam int CyclesPerTest = 40;
	localparam int MarginCycles = 200;
	localparam int ScanCycles = `OUTPUT_DIGITS * `REFRESH_CYCLES;

	logic Clock;
	logic Reset;
	logic Load;
	BinaryWord Value;
	BcdWord Bcd;
	logic BcdValid;
	SegmentWord Segments;
	logic [`OUTPUT_DIGITS-1:0] DigitEnable;

	// Rising edges since reset was released
	int CycleCount = 0;
	int Seed = 32'h1855;

	// Loads waiting for a result, with the edge Done should rise on
	BinaryWord ExpValue[$];
	int ExpCycle[$];

	// Digits the scanner should be showing
	BcdWord ShownBcd = '0;

	ClockGen i_ClockGen (
		.Clock (Clock),
		.Reset (Reset)
	);

	ValueDisplay i_ValueDisplay (
		.Clock         (Clock),
		.Reset         (Reset),
		.Load_i        (Load),
		.Value_i       (Value),
		.Bcd_o         (Bcd),
		.BcdValid_o    (BcdValid),
		.Segments_o    (Segments),
		.DigitEnable_o (DigitEnable)
	);

	always @(posedge Clock) begin
		if (Reset) begin
			CycleCount <= CycleCount + 1;
		end
	end

	// Decimal digits by repeated division, ones digit first
	function automatic BcdWord toBcd(BinaryWord value);
		BcdWord digits;
		int rest;
		rest = value;
		for (int k = 0; k < `OUTPUT_DIGITS; k++) begin
			digits[k] = BcdDigit'(rest % 10);
			rest = rest / 10;
		end
		return digits;
	endfunction

	// Expected active-low segments for one digit position, leading zeros dark
	function automatic SegmentWord segmentsOf(BcdWord digits, int index);
		logic [6:0] lit;
		int top;
		top = 0;
		for (int k = 1; k < `OUTPUT_DIGITS; k++) begin
			if (digits[k] != 4'd0) begin
				top = k;
			end
		end
		// Lit segments gfedcba, high means on
		case (digits[index])
			4'd0: lit = 7'h3F;
			4'd1: lit = 7'h06;
			4'd2: lit = 7'h5B;
			4'd3: lit = 7'h4F;
			4'd4: lit = 7'h66;
			4'd5: lit = 7'h6D;
			4'd6: lit = 7'h7D;
			4'd7: lit = 7'h07;
			4'd8: lit = 7'h7F;
			4'd9: lit = 7'h6F;
			default: lit = 7'h00;
		endcase
		if (index > top) begin
			lit = 7'h00;
		end
		return ~lit;
	endfunction

	// Digit position after a number of refresh periods
	function automatic int scanIndex(int cycles);
		return (cycles / `REFRESH_CYCLES) % `OUTPUT_DIGITS;
	endfunction

	function automatic logic [`OUTPUT_DIGITS-1:0] enableOf(int index);
		logic [`OUTPUT_DIGITS-1:0] enable;
		enable = '1;
		enable[index] = 1'b0;
		return enable;
	endfunction

	task automatic abortRun(string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic checkBcd(string name, BcdWord actual, BcdWord expected);
		if (actual !== expected) begin
			abortRun($sformatf("error %s: 0x%h, expected 0x%h", name, actual, expected));
		end
	endtask

	task automatic checkSegments(string name, SegmentWord actual, SegmentWord expected);
		if (actual !== expected) begin
			abortRun($sformatf("error %s: 0x%h, expected 0x%h", name, actual, expected));
		end
	endtask

	task automatic checkEnable(string name, logic [`OUTPUT_DIGITS-1:0] actual,
			logic [`OUTPUT_DIGITS-1:0] expected);
		if (actual !== expected) begin
			abortRun($sformatf("error %s: 0x%h, expected 0x%h", name, actual, expected));
		end
	endtask

	task automatic checkValid(string name, logic actual, logic expected);
		if (actual !== expected) begin
			abortRun($sformatf("error %s: 0x%h, expected 0x%h", name, actual, expected));
		end
	endtask

	task automatic checkCycle(string name, int actual, int expected);
		if (actual != expected) begin
			abortRun($sformatf("error %s: 0x%0h, expected 0x%0h", name, actual, expected));
		end
	endtask

	task automatic expectResult(BinaryWord value, int doneCycle);
		ExpValue.push_back(value);
		ExpCycle.push_back(doneCycle);
	endtask

	// Called on a falling edge, holds Load for one cycle
	task automatic driveLoad(BinaryWord value, output int loadCycle);
		Load = 1'b1;
		Value = value;
		loadCycle = CycleCount + 1;
		@(negedge Clock);
		Load = 1'b0;
	endtask

	task automatic waitForResults();
		while (ExpValue.size() != 0) begin
			@(negedge Clock);
		end
	endtask

	task automatic convertSingle(BinaryWord value);
		int loadCycle;
		@(negedge Clock);
		driveLoad(value, loadCycle);
		expectResult(value, loadCycle + Latency);
		waitForResults();
	endtask

	// Convert, then let the scanner make a full pass
	task automatic showValue(BinaryWord value);
		convertSingle(value);
		repeat (ScanCycles + 1) @(negedge Clock);
	endtask

	initial begin : Stimulus
		int loadCycle;
		int firstCycle;
		int unusedCycle;
		BinaryWord value;
		Load = 1'b0;
		Value = '0;
		wait (Reset === 1'b1);
		@(negedge Clock);

		// State right after reset
		checkBcd("Bcd_o", Bcd, '0);
		checkValid("BcdValid_o", BcdValid, 1'b0);
		checkEnable("DigitEnable_o", DigitEnable, enableOf(0));
		checkSegments("Segments_o", Segments, segmentsOf('0, 0));

		convertSingle(16'd0);
		convertSingle(16'd9);
		convertSingle(16'd10);
		convertSingle(16'd9999);
		convertSingle(16'd10000);
		convertSingle(16'd65535);

		for (int n = 0; n < RandomLoads; n++) begin
			value = BinaryWord'($random(Seed));
			convertSingle(value);
		end

		// Second load lands while the start is in flight, the last one wins
		@(negedge Clock);
		driveLoad(16'd31415, firstCycle);
		expectResult(16'd31415, firstCycle + Latency);
		driveLoad(16'd2718, unusedCycle);
		repeat (5) @(negedge Clock);
		driveLoad(16'd1414, unusedCycle);
		repeat (5) @(negedge Clock);
		driveLoad(16'd42, unusedCycle);
		expectResult(16'd42, firstCycle + 2 * Latency);
		waitForResults();
		// A stray result for a replaced value would show up here
		repeat (Latency + 2) @(negedge Clock);

		showValue(16'd7);
		showValue(16'd305);
		showValue(16'd4020);
		showValue(16'd60001);

		// Load in the Done cycle with nothing pending
		@(negedge Clock);
		driveLoad(16'd5050, loadCycle);
		expectResult(16'd5050, loadCycle + Latency);
		do begin
			@(negedge Clock);
		end while (BcdValid !== 1'b1);
		driveLoad(16'd60606, loadCycle);
		expectResult(16'd60606, loadCycle + Latency);

		repeat (Latency + 2) @(negedge Clock);
		if (ExpValue.size() == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			abortRun("Some loads never produced a result");
		end
	end

	// Checks the display every cycle and each result as it arrives
	initial begin : Scoreboard
		int index;
		int doneCycle;
		BinaryWord value;
		wait (Reset === 1'b1);
		forever begin
			@(negedge Clock);
			index = scanIndex(CycleCount);
			checkEnable("DigitEnable_o", DigitEnable, enableOf(index));
			checkSegments("Segments_o", Segments, segmentsOf(ShownBcd, index));
			if (BcdValid === 1'b1) begin
				if (ExpValue.size() == 0) begin
					abortRun("BcdValid_o pulsed with no load waiting for a result");
				end else begin
					value = ExpValue.pop_front();
					doneCycle = ExpCycle.pop_front();
					checkCycle("BcdValid_o cycle", CycleCount, doneCycle);
					checkBcd("Bcd_o", Bcd, toBcd(value));
					// Scanner latches it on the next edge
					ShownBcd = toBcd(value);
				end
			end else begin
				checkBcd("Bcd_o", Bcd, ShownBcd);
			end
		end
	end

	initial begin : Watchdog
		repeat (TestCount * CyclesPerTest + MarginCycles) @(posedge Clock);
		abortRun("Run timed out before all tests finished");
	end

endmodule

/* sources.f */
+incdir+common
common/DisplayPkg.sv
common/ConvertIf.sv
rtl/ConversionControl.sv
DoubleDabble/DoubleDabble.sv
DisplayScanner/DisplayScanner.sv
rtl/ValueDisplay.sv
verif/ClockGen.sv
verif/ValueDisplayTb.sv
